// ==== dv/tb_clock_gen.sv ====
/*
 * Free-running testbench clock, low at time zero.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // half period high, half period low
  always begin
    #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== dv/tb_slow_mem_checks.sv ====
/*
 * Checker on the slave's bus ports. Compares each response with the head of
 * the expected queue from the testbench and counts every failed assertion.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_slow_mem_checks (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  logic                                gnt_i,
  input  logic                                rvalid_i,
  input  logic [slow_mem_pkg::DATA_WIDTH-1:0] rdata_i,
  input  logic [slow_mem_pkg::DATA_WIDTH-1:0] exp_head_i,
  input  int                                  exp_cnt_i,
  output int                                  data_errs_o,
  output int                                  proto_errs_o
);

  import slow_mem_pkg::*;

  // set after the first edge seen in reset, when the pipeline is cleared
  logic reset_seen = 1'b0;

  initial begin
    data_errs_o  = 0;
    proto_errs_o = 0;
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      reset_seen <= 1'b1;
    end
  end

  // response data against the oldest outstanding request
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> (rdata_i == exp_head_i))
  else begin
    data_errs_o = data_errs_o + 1;
    $display("FAILED %0t rdata_o expected %08h actual %08h",
             $time, $sampled(exp_head_i), $sampled(rdata_i));
  end

  // no response without a granted request behind it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> (exp_cnt_i != 0))
  else begin
    proto_errs_o = proto_errs_o + 1;
    $display("at %0t a response arrived with no request outstanding", $time);
  end

  // grant only answers a request
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_i |-> req_i)
  else begin
    proto_errs_o = proto_errs_o + 1;
    $display("FAILED %0t gnt_o expected 0 actual 1", $time);
  end

  // grant may only be withheld once the queue can be full
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i && !gnt_i) |-> (exp_cnt_i >= REQ_QUEUE_DEPTH))
  else begin
    proto_errs_o = proto_errs_o + 1;
    $display("FAILED %0t gnt_o expected 1 actual 0", $time);
  end

  // queue plus pipeline bound what can be in flight
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exp_cnt_i <= (REQ_QUEUE_DEPTH + READ_LATENCY))
  else begin
    proto_errs_o = proto_errs_o + 1;
    $display("at %0t more requests are outstanding than queue and pipeline hold", $time);
  end

  assert property (@(posedge clk_i)
    (!rst_n_i && reset_seen) |-> !rvalid_i)
  else begin
    proto_errs_o = proto_errs_o + 1;
    $display("FAILED %0t rvalid_o expected 0 actual %0b during reset",
             $time, $sampled(rvalid_i));
  end

  // release cycle and first free-running cycle
  assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!rvalid_i ##1 !rvalid_i))
  else begin
    proto_errs_o = proto_errs_o + 1;
    $display("FAILED %0t rvalid_o expected 0 actual %0b after reset",
             $time, $sampled(rvalid_i));
  end

endmodule

`default_nettype wire

// ==== dv/tb_slow_mem_slave.sv ====
/*
 * Testbench top for the slow memory slave: reset, directed and random bus
 * traffic, a reference memory with an expected response queue, final report.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_slow_mem_slave;

  import slow_mem_pkg::*;

  localparam int RESET_CYCLES  = 8;
  localparam int FILL_REQS     = MEM_WORDS;
  localparam int DIRECTED_REQS = 34;
  localparam int BURST_REQS    = 24;
  localparam int RANDOM_REQS   = 300;
  localparam int TOTAL_REQS    = FILL_REQS + DIRECTED_REQS + BURST_REQS + RANDOM_REQS;
  localparam int DRAIN_CYCLES  = 6 * (REQ_QUEUE_DEPTH + READ_LATENCY + 2);
  // slowest rate is two cycles per request, doubled for margin
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 2 * TOTAL_REQS + DRAIN_CYCLES);

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic                  we;
  logic [BE_WIDTH-1:0]   be;
  logic [ADDR_WIDTH-1:0] addr;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  gnt;
  logic                  rvalid;
  logic [DATA_WIDTH-1:0] rdata;

  // reference model state
  logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
  logic [DATA_WIDTH-1:0] exp_q [$];
  logic [DATA_WIDTH-1:0] exp_head = '0;
  int                    exp_cnt = 0;
  int                    grant_cnt = 0;
  int                    resp_cnt = 0;
  int                    cycle_cnt = 0;
  int                    count_errs = 0;
  int                    data_errs;
  int                    proto_errs;
  int                    seed = 83;

  tb_clock_gen #(.PERIOD_NS(100)) clock_gen (.clk_o(clk));

  slow_mem_slave UUT (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .req_i    (req),
    .we_i     (we),
    .be_i     (be),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (rdata)
  );

  tb_slow_mem_checks checks (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .gnt_i        (gnt),
    .rvalid_i     (rvalid),
    .rdata_i      (rdata),
    .exp_head_i   (exp_head),
    .exp_cnt_i    (exp_cnt),
    .data_errs_o  (data_errs),
    .proto_errs_o (proto_errs)
  );

  // enabled bytes come from the new data, the rest stay
  function automatic logic [DATA_WIDTH-1:0] merge_bytes(
    input logic [DATA_WIDTH-1:0] old_word,
    input logic [DATA_WIDTH-1:0] new_word,
    input logic [BE_WIDTH-1:0]   byte_en
  );
    logic [DATA_WIDTH-1:0] result;
    result = old_word;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (byte_en[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] fill_pattern(input logic [7:0] idx);
    return {idx ^ 8'h5a, ~idx, idx, idx + 8'h11};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] word_address(
    input logic [21:0] upper,
    input logic [7:0]  idx
  );
    return {upper, idx, 2'b00};
  endfunction

  // model follows the bus at each rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (rvalid) begin
        resp_cnt++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (req && gnt) begin
        grant_cnt++;
        if (we) begin
          ref_mem[addr[9:2]] = merge_bytes(ref_mem[addr[9:2]], wdata, be);
          exp_q.push_back('0);
        end else begin
          exp_q.push_back(ref_mem[addr[9:2]]);
        end
      end
    end
    exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    exp_cnt  = exp_q.size();
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d responses still missing",
               cycle_cnt, exp_cnt);
      $display("errors: data %0d, protocol %0d, count %0d",
               data_errs, proto_errs, count_errs);
      $display("Something failed");
      $finish;
    end
  end

  // called on a falling edge, returns on the falling edge after the grant
  task automatic send_req(
    input logic                  req_we,
    input logic [BE_WIDTH-1:0]   req_be,
    input logic [ADDR_WIDTH-1:0] req_addr,
    input logic [DATA_WIDTH-1:0] req_wdata
  );
    req   = 1'b1;
    we    = req_we;
    be    = req_be;
    addr  = req_addr;
    wdata = req_wdata;
    @(posedge clk);
    while (!gnt) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic go_idle(input int cycles);
    req   = 1'b0;
    we    = 1'b0;
    be    = '0;
    addr  = '0;
    wdata = '0;
    repeat (cycles) @(negedge clk);
  endtask

  task automatic wait_drain();
    go_idle(1);
    while (exp_cnt != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic                  r_we;
    logic [BE_WIDTH-1:0]   r_be;
    logic [ADDR_WIDTH-1:0] r_addr;
    logic [DATA_WIDTH-1:0] r_wdata;
    int                    gap;

    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    be    = '0;
    addr  = '0;
    wdata = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // back-to-back writes give every word a known value
    for (int i = 0; i < FILL_REQS; i++) begin
      send_req(1'b1, 4'hf, word_address(22'h0, 8'(i)), fill_pattern(8'(i)));
    end
    wait_drain();

    send_req(1'b1, 4'hf, word_address(22'h0, 8'h05), 32'hdeadbeef);
    send_req(1'b0, 4'hf, word_address(22'h0, 8'h05), '0);
    wait_drain();

    // every partial byte-enable pattern, each followed by a read
    for (int p = 1; p < 15; p++) begin
      send_req(1'b1, 4'(p), word_address(22'h0, 8'(16 + p)), 32'ha1b2c3d4);
      go_idle(1);
      send_req(1'b0, 4'hf, word_address(22'h0, 8'(16 + p)), '0);
    end
    wait_drain();

    // upper address bits alias onto the same word
    send_req(1'b1, 4'hf, word_address(22'h2a5f3, 8'hc3), 32'h0badcafe);
    send_req(1'b0, 4'hf, word_address(22'h0f00d, 8'hc3), '0);
    send_req(1'b1, 4'h6, word_address(22'h3ffff, 8'h40), 32'h77665544);
    send_req(1'b0, 4'hf, word_address(22'h12345, 8'h40), '0);
    wait_drain();

    // requests held high with no gaps
    for (int i = 0; i < BURST_REQS; i++) begin
      send_req(i[0], 4'hf, word_address(22'(i * 3), 8'(i % 6)), 32'(i * 32'h01010101));
    end
    wait_drain();

    for (int n = 0; n < RANDOM_REQS; n++) begin
      r_we    = $random(seed);
      r_be    = $random(seed);
      r_addr  = $random(seed);
      r_wdata = $random(seed);
      gap     = $unsigned($random(seed)) % 2;
      send_req(r_we, r_be, r_addr, r_wdata);
      if (gap > 0) begin
        go_idle(gap);
      end
    end
    wait_drain();
    go_idle(READ_LATENCY + 2);

    assert (resp_cnt == grant_cnt)
    else begin
      count_errs++;
      $display("FAILED %0t rvalid_o pulse count expected %0d actual %0d",
               $time, grant_cnt, resp_cnt);
    end

    $display("errors: data %0d, protocol %0d, count %0d",
             data_errs, proto_errs, count_errs);
    if ((data_errs + proto_errs + count_errs) == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== slow_mem_slave.f ====
source/slow_mem_pkg.sv
source/mem_access_if.sv
source/obi_req_queue.sv
source/slow_mem_array.sv
source/slow_mem_slave.sv
dv/tb_clock_gen.sv
dv/tb_slow_mem_checks.sv
dv/tb_slow_mem_slave.sv

// ==== source/mem_access_if.sv ====
/*
 * One dequeued access, passed from the request queue to the memory.
 * The queue drives every field, the memory only samples them.
 */
`timescale 1ns/10ps
`default_nettype none

interface mem_access_if;

  import slow_mem_pkg::*;

  // one-cycle strobe per popped entry
  logic                       valid;
  logic                       we;
  logic [BE_WIDTH-1:0]        be;
  logic [WORD_ADDR_WIDTH-1:0] word_addr;
  logic [DATA_WIDTH-1:0]      wdata;

  modport queue (
    output valid,
    output we,
    output be,
    output word_addr,
    output wdata
  );

  modport mem (
    input valid,
    input we,
    input be,
    input word_addr,
    input wdata
  );

endinterface

`default_nettype wire

// ==== source/obi_req_queue.sv ====
/*
 * Request side of the slave: grants bus requests into a small circular FIFO
 * and hands one stored access per cycle to the memory.
 */
`timescale 1ns/10ps
`default_nettype none

module obi_req_queue (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [slow_mem_pkg::BE_WIDTH-1:0]   be_i,
  input  logic [slow_mem_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [slow_mem_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic                             gnt_o,
  mem_access_if.queue                      acc
);

  import slow_mem_pkg::*;

  // entry storage
  logic                       we_q    [REQ_QUEUE_DEPTH];
  logic [BE_WIDTH-1:0]        be_q    [REQ_QUEUE_DEPTH];
  logic [WORD_ADDR_WIDTH-1:0] waddr_q [REQ_QUEUE_DEPTH];
  logic [DATA_WIDTH-1:0]      wdata_q [REQ_QUEUE_DEPTH];

  logic [QUEUE_PTR_WIDTH-1:0] wr_ptr_q;
  logic [QUEUE_PTR_WIDTH-1:0] rd_ptr_q;
  logic [QUEUE_CNT_WIDTH-1:0] cnt_q;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (cnt_q == QUEUE_CNT_WIDTH'(REQ_QUEUE_DEPTH));
  assign empty = (cnt_q == '0);

  // grant in the same cycle as long as there is room
  assign gnt_o = req_i && !full;
  assign push  = gnt_o;
  // the memory never refuses, so every non-empty cycle pops
  assign pop   = !empty;

  assign acc.valid     = pop;
  assign acc.we        = we_q[rd_ptr_q];
  assign acc.be        = be_q[rd_ptr_q];
  assign acc.word_addr = waddr_q[rd_ptr_q];
  assign acc.wdata     = wdata_q[rd_ptr_q];

  // only the word index is kept, upper address bits alias
  always_ff @(posedge clk_i) begin
    if (push) begin
      we_q[wr_ptr_q]    <= we_i;
      be_q[wr_ptr_q]    <= be_i;
      waddr_q[wr_ptr_q] <= addr_i[WORD_ADDR_LSB +: WORD_ADDR_WIDTH];
      wdata_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_q == QUEUE_PTR_WIDTH'(REQ_QUEUE_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == QUEUE_PTR_WIDTH'(REQ_QUEUE_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // occupancy moves only when one side acts alone
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // occupancy stays within the storage
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_q <= QUEUE_CNT_WIDTH'(REQ_QUEUE_DEPTH));

  // a fresh strobe needs an entry granted on the cycle before
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(acc.valid) |-> $past(req_i && gnt_o));

endmodule

`default_nettype wire

// ==== source/slow_mem_array.sv ====
/*
 * Word memory of the slave with byte-enable writes and a fixed-latency
 * response pipeline. Every access, read or write, yields one response.
 */
`timescale 1ns/10ps
`default_nettype none

module slow_mem_array (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  mem_access_if.mem                         acc,
  output logic                              rvalid_o,
  output logic [slow_mem_pkg::DATA_WIDTH-1:0] rdata_o
);

  import slow_mem_pkg::*;

  logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];

  // current word, incoming data and their byte merge
  mem_word_u stored_word;
  mem_word_u write_word;
  mem_word_u merged_word;

  // response pipeline, stage 0 is filled by the access itself
  logic [READ_LATENCY-1:0]                 valid_q;
  logic [READ_LATENCY-1:0][DATA_WIDTH-1:0] data_q;
  logic [DATA_WIDTH-1:0]                   resp_data;

  always_comb begin
    stored_word.word = mem_q[acc.word_addr];
    write_word.word  = acc.wdata;
    merged_word.word = stored_word.word;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (acc.be[b]) begin
        merged_word.bytes[b] = write_word.bytes[b];
      end
    end
  end

  // writes answer with zero, reads with the word seen this cycle
  assign resp_data = acc.we ? '0 : stored_word.word;

  always_ff @(posedge clk_i) begin
    if (acc.valid && acc.we) begin
      mem_q[acc.word_addr] <= merged_word.word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= acc.valid;
      for (int s = 1; s < READ_LATENCY; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_q[0] <= resp_data;
    for (int s = 1; s < READ_LATENCY; s++) begin
      data_q[s] <= data_q[s-1];
    end
  end

  assign rvalid_o = valid_q[READ_LATENCY-1];
  assign rdata_o  = data_q[READ_LATENCY-1];

  // each strobe from the queue comes back exactly READ_LATENCY cycles later
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc.valid |-> ##READ_LATENCY rvalid_o);

  // and no response appears without such a strobe
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |-> $past(acc.valid, READ_LATENCY));

endmodule

`default_nettype wire

// ==== source/slow_mem_pkg.sv ====
/*
 * Shared widths, sizes and latency of the slow memory slave.
 * Modules import it in their body and use scoped names in their headers.
 */
`default_nettype none

package slow_mem_pkg;

  // bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int BYTE_WIDTH = 8;
  localparam int BE_WIDTH = DATA_WIDTH / BYTE_WIDTH;

  // word memory, indexed by address bits 9..2
  localparam int MEM_WORDS = 256;
  localparam int WORD_ADDR_WIDTH = $clog2(MEM_WORDS);
  localparam int WORD_ADDR_LSB = $clog2(BE_WIDTH);

  // request queue sizing
  localparam int REQ_QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_WIDTH = $clog2(REQ_QUEUE_DEPTH);
  localparam int QUEUE_CNT_WIDTH = $clog2(REQ_QUEUE_DEPTH + 1);

  // cycles from memory access to response
  localparam int READ_LATENCY = 4;

  // one stored word, seen whole or as single bytes
  typedef union packed {
    logic [DATA_WIDTH-1:0]                word;
    logic [BE_WIDTH-1:0][BYTE_WIDTH-1:0]  bytes;
  } mem_word_u;

endpackage

`default_nettype wire

// ==== source/slow_mem_slave.sv ====
/*
 * Slow memory slave on an OBI-style bus: request queue in front of a
 * word memory with fixed read latency. Plain bus ports for integration.
 */
`timescale 1ns/10ps
`default_nettype none

module slow_mem_slave (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [slow_mem_pkg::BE_WIDTH-1:0]   be_i,
  input  logic [slow_mem_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [slow_mem_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output logic [slow_mem_pkg::DATA_WIDTH-1:0] rdata_o
);

  // accesses popped from the queue
  mem_access_if acc_if ();

  obi_req_queue req_queue_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .we_i    (we_i),
    .be_i    (be_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .gnt_o   (gnt_o),
    .acc     (acc_if.queue)
  );

  // memory also drives the bus response
  slow_mem_array mem_array_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .acc      (acc_if.mem),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o)
  );

endmodule

`default_nettype wire
